// File: filelist.f
hdl/fhp_pkg.sv
hdl/fhp_tlv_parser.sv
hdl/fhp_phd_buffer.sv
hdl/fhp_phd_sender.sv
hdl/fhp_data_framer.sv
hdl/fhp_top.sv
bench/fhp_tb_assertions.sv
bench/fhp_tb.sv

// File: Bender.yml
package:
  name: fhp

sources:
  - hdl/fhp_pkg.sv
  - hdl/fhp_tlv_parser.sv
  - hdl/fhp_phd_buffer.sv
  - hdl/fhp_phd_sender.sv
  - hdl/fhp_data_framer.sv
  - hdl/fhp_top.sv
  - target: test
    files:
      - bench/fhp_tb_assertions.sv
      - bench/fhp_tb.sv

// File: bench/fhp_tb.sv
/*
   Testbench for the TLV front end header parser.
   All stimulus is built at time zero and served from a queue. Header
   and data ready levels and gaps in the source are random. A PHD TLV
   carries six header beats and one check word, data TLVs carry one
   to five data beats.
*/
`timescale 1ns/10ps
`default_nettype none

module fhp_tb;
   import fhp_pkg::*;

   localparam int NUM_FRAMES = 15;

   logic      clk;
   logic      rst_n;
   tlv_beat_t usr_tlv;
   logic      usr_empty;
   logic      usr_rd;
   phd_beat_t phd_bus;
   logic      phd_valid;
   logic      phd_ready;
   dp_bus_t   dp_bus;
   logic      dp_valid;
   logic      dp_ready;
   sof_bus_t  sof_bus;
   logic      sof_valid;
   eof_bus_t  eof_bus;

   logic [31:0] lfsr = 32'ha2757ef5;
   logic        gen_done = 1'b0;
   logic        pending_phd = 1'b0;   // a PHD TLV was queued since the last data TLV.
   int          src_idx = 0;
   tlv_beat_t   src_q[$];
   phd_beat_t   exp_phd_q[$];
   dp_bus_t     exp_dp_q[$];
   sof_bus_t    exp_sof_q[$];
   eof_bus_t    exp_eof_q[$];
   tlv_type_e   discard_types[5] = '{tlv_rqe, tlv_cmd, tlv_frmd, tlv_pfd, tlv_cqe};

   fhp_top i_fhp_top (
      .clk       (clk),
      .rst_n     (rst_n),
      .usr_tlv   (usr_tlv),
      .usr_empty (usr_empty),
      .usr_rd    (usr_rd),
      .phd_bus   (phd_bus),
      .phd_valid (phd_valid),
      .phd_ready (phd_ready),
      .dp_bus    (dp_bus),
      .dp_valid  (dp_valid),
      .dp_ready  (dp_ready),
      .sof_bus   (sof_bus),
      .sof_valid (sof_valid),
      .eof_bus   (eof_bus)
   );

   bind fhp_top fhp_tb_assertions i_assertions (
      .clk       (clk),
      .rst_n     (rst_n),
      .usr_rd    (usr_rd),
      .usr_empty (usr_empty),
      .phd_bus   (phd_bus),
      .phd_valid (phd_valid),
      .phd_ready (phd_ready),
      .dp_valid  (dp_valid),
      .sof_valid (sof_valid)
   );

   // fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic logic [63:0] rand_word();
      logic [63:0] w;
      w[63:32] = rand_bits(32);
      w[31:0]  = rand_bits(32);
      return w;
   endfunction

   function automatic tlv_beat_t make_beat(input logic [63:0] d, input logic [7:0] strb,
                                           input logic sot, input logic eot,
                                           input logic [7:0] typ);
      tlv_beat_t b;
      b.tdata = d;
      b.tstrb = strb;
      b.sot   = sot;
      b.eot   = eot;
      b.typen = typ;
      return b;
   endfunction

   function automatic logic [63:0] signature_word(input int kind);
      logic [63:0] w;
      w = rand_word();
      case (kind)
         0:       w[31:0] = XP9_MAGIC;
         1:       w[31:0] = XP10_MAGIC;
         2:       w[15:0] = {GZIP_ID2, GZIP_ID1};
         3:       w[3:0]  = ZLIB_CM;
         default: w[3:0]  = 4'h3;   // matches no known signature.
      endcase
      return w;
   endfunction

   // expected start-of-frame report from the start word and first data beat.
   function automatic sof_bus_t ref_sof(input logic [63:0] w0, input logic [63:0] d0,
                                        input logic phd);
      sof_bus_t s;
      s.frame_num   = w0[18:8];
      s.eng_id      = w0[22:19];
      s.seq_num     = w0[30:23];
      s.phd_present = phd;
      s.err         = no_error;
      if (d0[31:0] == 32'h5a4d_5839) begin
         s.fmt = xp9;
      end else if (d0[31:0] == 32'h5a4d_5830) begin
         s.fmt = xp10;
      end else if (d0[15:0] == 16'h8b1f) begin
         s.fmt = gzip;
      end else if (d0[3:0] == 4'h8) begin
         s.fmt = zlib;
      end else begin
         s.fmt = none;
         s.err = bad_format;
      end
      return s;
   endfunction

   function automatic eof_bus_t ref_eof(input int nbeats, input int last_bytes,
                                        input logic last_cmd);
      eof_bus_t e;
      e.frm_bytes = 28'(8 * (nbeats - 1) + last_bytes);
      e.last      = last_cmd;
      return e;
   endfunction

   task automatic stop_with_fail(input string line);
      $display("%s", line);
      $display("Test FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic add_phd();
      logic [63:0] w;
      phd_beat_t   hb;
      w      = rand_word();
      w[7:0] = tlv_phd;
      src_q.push_back(make_beat(w, 8'hff, 1'b1, 1'b0, tlv_phd));
      for (int j = 0; j < PHD_WORDS; j++) begin
         hb.data = rand_word();
         hb.last = (j == PHD_WORDS - 1);
         src_q.push_back(make_beat(hb.data, 8'hff, 1'b0, 1'b0, 8'h00));
         exp_phd_q.push_back(hb);
      end
      src_q.push_back(make_beat(rand_word(), 8'hff, 1'b0, 1'b1, 8'h00));   // check word.
      pending_phd = 1'b1;
   endtask

   task automatic add_discard();
      tlv_type_e   typ;
      logic [63:0] w;
      int          n;
      typ = discard_types[rand_bits(3) % 5];
      n   = 1 + int'(rand_bits(2) % 3);
      for (int j = 0; j < n; j++) begin
         w = rand_word();
         if (j == 0) begin
            w[7:0] = typ;
         end
         src_q.push_back(make_beat(w, 8'hff, j == 0, j == n - 1, typ));
      end
   endtask

   task automatic add_data(input int kind);
      logic [63:0] w0;
      logic [63:0] d0;
      logic [63:0] w;
      logic [7:0]  strb;
      logic        eot;
      dp_bus_t     dexp;
      int          n;
      int          k;
      w0      = rand_word();
      w0[7:0] = tlv_data;
      n       = 1 + int'(rand_bits(3) % 5);
      k       = 1 + int'(rand_bits(3));
      d0      = signature_word(kind);
      src_q.push_back(make_beat(w0, 8'hff, 1'b1, 1'b0, tlv_data));
      for (int j = 0; j < n; j++) begin
         w    = (j == 0) ? d0 : rand_word();
         eot  = (j == n - 1);
         strb = eot ? 8'((1 << k) - 1) : 8'hff;
         src_q.push_back(make_beat(w, strb, 1'b0, eot, 8'h00));
         dexp.data        = w;
         dexp.sof         = (j == 0);
         dexp.eof         = eot;
         dexp.bytes_valid = eot ? 3'(k) : 3'd0;   // eight bytes wrap to 0.
         exp_dp_q.push_back(dexp);
      end
      exp_sof_q.push_back(ref_sof(w0, d0, pending_phd));
      exp_eof_q.push_back(ref_eof(n, k, w0[31]));
      pending_phd = 1'b0;
   endtask

   task automatic build_stimulus();
      for (int f = 0; f < NUM_FRAMES; f++) begin
         if ((f % 3) != 2) begin
            add_phd();
         end
         if ((f % 2) == 1) begin
            add_discard();
         end
         add_data(f % 5);
      end
      add_discard();
   endtask

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   // the source model takes a beat on every edge that sees usr_rd high.
   always @(posedge clk) begin
      if (usr_rd) begin
         src_idx = src_idx + 1;
      end
      if (rst_n) begin
         phd_ready <= (rand_bits(2) != 0);
         dp_ready  <= (rand_bits(2) != 0);
      end
      if (rst_n && (src_idx < src_q.size()) && (rand_bits(3) != 0)) begin
         usr_tlv   <= src_q[src_idx];
         usr_empty <= 1'b0;
      end else begin
         usr_empty <= 1'b1;
      end
   end

   always @(negedge clk) begin
      phd_beat_t ph;
      dp_bus_t   dp;
      sof_bus_t  sf;
      eof_bus_t  ef;
      if (rst_n) begin
         assert (i_fhp_top.i_assertions.err_cnt == 0)
            else stop_with_fail("a bound handshake assertion fired");
         if (phd_valid && phd_ready) begin
            assert (exp_phd_q.size() > 0)
               else stop_with_fail("a header beat left the DUT when none was expected");
            ph = exp_phd_q.pop_front();
            assert (phd_bus == ph)
               else stop_with_fail($sformatf("[FAIL] %0t: header beat %h, expected %h",
                                             $time, phd_bus, ph));
         end
         if (dp_valid) begin
            assert (exp_dp_q.size() > 0)
               else stop_with_fail("a data beat left the DUT when none was expected");
            dp = exp_dp_q.pop_front();
            assert ((dp_bus == dp) && (sof_valid == dp.sof))
               else stop_with_fail($sformatf("[FAIL] %0t: data beat %h sof_valid %b, expected %h",
                                             $time, dp_bus, sof_valid, dp));
            if (dp.eof) begin
               ef = exp_eof_q.pop_front();
               assert (eof_bus == ef)
                  else stop_with_fail($sformatf("[FAIL] %0t: eof report %h, expected %h",
                                                $time, eof_bus, ef));
            end
         end
         if (sof_valid) begin
            assert (exp_sof_q.size() > 0)
               else stop_with_fail("a start-of-frame report came with no frame expected");
            sf = exp_sof_q.pop_front();
            assert (sof_bus == sf)
               else stop_with_fail($sformatf("[FAIL] %0t: sof report %h, expected %h",
                                             $time, sof_bus, sf));
         end
      end
   end

   initial begin
      wait (gen_done);
      repeat (40 * src_q.size()) @(posedge clk);
      stop_with_fail($sformatf("timeout at %0t with expected outputs still missing", $time));
   end

   initial begin
      rst_n     = 1'b0;
      usr_tlv   = '0;
      usr_empty = 1'b1;
      phd_ready = 1'b0;
      dp_ready  = 1'b0;
      build_stimulus();
      gen_done = 1'b1;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      while ((src_idx < src_q.size()) || (exp_phd_q.size() != 0) || (exp_dp_q.size() != 0) ||
             (exp_sof_q.size() != 0) || (exp_eof_q.size() != 0)) begin
         @(posedge clk);
      end
      repeat (20) @(posedge clk);   // stray outputs during this quiet time fail in the checker.
      if ((exp_phd_q.size() == 0) && (exp_dp_q.size() == 0) &&
          (i_fhp_top.i_assertions.err_cnt == 0)) begin
         $display("Test OK");
         $finish;
      end else begin
         stop_with_fail("outputs were still missing at the end of the run");
      end
   end

endmodule

`default_nettype wire

// File: bench/fhp_tb_assertions.sv
/*
   Handshake checks bound into the front end top level.
   All checks are off while reset is low. err_cnt holds the number
   of failed checks.
*/
`timescale 1ns/10ps
`default_nettype none

module fhp_tb_assertions (
   input logic               clk,
   input logic               rst_n,
   input logic               usr_rd,
   input logic               usr_empty,
   input fhp_pkg::phd_beat_t phd_bus,
   input logic               phd_valid,
   input logic               phd_ready,
   input logic               dp_valid,
   input logic               sof_valid
);
   int unsigned err_cnt = 0;

   phd_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (phd_valid && !phd_ready) |=> (phd_valid && $stable(phd_bus)))
      else begin
         $error("header beat changed while stalled");
         err_cnt++;
      end

   no_read_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
      !(usr_rd && usr_empty))
      else begin
         $error("source read while it was empty");
         err_cnt++;
      end

   sof_with_data: assert property (@(posedge clk) disable iff (!rst_n)
      sof_valid |-> dp_valid)
      else begin
         $error("start of frame without a data beat");
         err_cnt++;
      end

endmodule

`default_nettype wire

// File: hdl/fhp_top.sv
/*
   Top level of the TLV front end header parser.
   Header beats leave through an 8-deep FIFO, data beats leave two
   cycles after their read. dp_ready only throttles reads while a
   data TLV is open, beats in flight are still delivered.
*/
`timescale 1ns/10ps
`default_nettype none

module fhp_top (
   input  logic               clk,
   input  logic               rst_n,
   input  fhp_pkg::tlv_beat_t usr_tlv,
   input  logic               usr_empty,
   output logic               usr_rd,
   output fhp_pkg::phd_beat_t phd_bus,
   output logic               phd_valid,
   input  logic               phd_ready,
   output fhp_pkg::dp_bus_t   dp_bus,
   output logic               dp_valid,
   input  logic               dp_ready,
   output fhp_pkg::sof_bus_t  sof_bus,
   output logic               sof_valid,
   output fhp_pkg::eof_bus_t  eof_bus
);
   import fhp_pkg::*;

   logic       phd_wr;
   phd_beat_t  phd_wdata;
   logic       phd_room;
   logic       phd_rd;
   phd_beat_t  phd_rdata;
   logic       phd_empty;
   logic       phd_done;
   logic       dat_valid;
   data_beat_t dat_beat;

   fhp_tlv_parser i_parser (
      .clk       (clk),
      .rst_n     (rst_n),
      .usr_tlv   (usr_tlv),
      .usr_empty (usr_empty),
      .usr_rd    (usr_rd),
      .dp_ready  (dp_ready),
      .phd_room  (phd_room),
      .phd_done  (phd_done),
      .phd_wr    (phd_wr),
      .phd_wdata (phd_wdata),
      .dat_valid (dat_valid),
      .dat_beat  (dat_beat)
   );

   fhp_phd_buffer i_buffer (
      .clk       (clk),
      .rst_n     (rst_n),
      .phd_wr    (phd_wr),
      .phd_wdata (phd_wdata),
      .phd_rd    (phd_rd),
      .phd_rdata (phd_rdata),
      .phd_empty (phd_empty),
      .phd_room  (phd_room)
   );

   fhp_phd_sender i_sender (
      .clk       (clk),
      .rst_n     (rst_n),
      .phd_rdata (phd_rdata),
      .phd_empty (phd_empty),
      .phd_rd    (phd_rd),
      .phd_bus   (phd_bus),
      .phd_valid (phd_valid),
      .phd_ready (phd_ready),
      .phd_done  (phd_done)
   );

   fhp_data_framer i_framer (
      .clk       (clk),
      .rst_n     (rst_n),
      .dat_valid (dat_valid),
      .dat_beat  (dat_beat),
      .dp_bus    (dp_bus),
      .dp_valid  (dp_valid),
      .sof_bus   (sof_bus),
      .sof_valid (sof_valid),
      .eof_bus   (eof_bus)
   );

endmodule

`default_nettype wire

// File: hdl/fhp_data_framer.sv
/*
   Turns the beats of a data TLV into data port, sof and eof reports.
   The start word only sets up the frame, it gives no data beat.
   The eot strobe is taken to be contiguous from byte 0. Format
   detection looks at the first data beat only.
*/
`timescale 1ns/10ps
`default_nettype none

module fhp_data_framer (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                dat_valid,
   input  fhp_pkg::data_beat_t dat_beat,
   output fhp_pkg::dp_bus_t    dp_bus,
   output logic                dp_valid,
   output fhp_pkg::sof_bus_t   sof_bus,
   output logic                sof_valid,
   output fhp_pkg::eof_bus_t   eof_bus
);
   import fhp_pkg::*;

   tlv_beat_t   beat;
   tlv_word0_u  word0;
   sof_fmt_e    fmt;
   fhp_err_e    err;
   logic [3:0]  nbytes;
   logic        first;
   logic        last_cmd;
   logic [27:0] acc;

   function automatic logic [3:0] strb_bytes(input logic [7:0] strb);
      logic [3:0] n;
      n = '0;
      for (int i = 0; i < BYTES_PER_BEAT; i++) begin
         n = n + 4'(strb[i]);
      end
      return n;
   endfunction

   assign beat   = dat_beat.tlv;
   assign word0  = beat.tdata;
   assign nbytes = strb_bytes(beat.tstrb);

   always_comb begin
      fmt = none;
      err = no_error;
      if (beat.tdata[31:0] == XP9_MAGIC) begin
         fmt = xp9;
      end else if (beat.tdata[31:0] == XP10_MAGIC) begin
         fmt = xp10;
      end else if ((beat.tdata[7:0] == GZIP_ID1) && (beat.tdata[15:8] == GZIP_ID2)) begin
         fmt = gzip;
      end else if (beat.tdata[3:0] == ZLIB_CM) begin
         fmt = zlib;
      end else begin
         err = bad_format;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp_valid  <= 1'b0;
         sof_valid <= 1'b0;
         first     <= 1'b0;
         acc       <= '0;
      end else begin
         dp_valid  <= dat_valid && !beat.sot;
         sof_valid <= dat_valid && !beat.sot && first;
         if (dat_valid) begin
            if (beat.sot) begin
               first <= 1'b1;
               acc   <= '0;
            end else begin
               first <= 1'b0;
               acc   <= beat.eot ? '0 : acc + 28'(BYTES_PER_BEAT);
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (dat_valid && beat.sot) begin
         sof_bus.frame_num   <= word0.data.frame_num;
         sof_bus.eng_id      <= word0.data.eng_id;
         sof_bus.seq_num     <= word0.data.seq_num;
         sof_bus.phd_present <= dat_beat.phd_seen;
         last_cmd            <= word0.data.last_of_command;
      end
      if (dat_valid && !beat.sot) begin
         dp_bus.data        <= beat.tdata;
         dp_bus.sof         <= first;
         dp_bus.eof         <= beat.eot;
         dp_bus.bytes_valid <= beat.eot ? nbytes[2:0] : 3'd0;   // a full strobe wraps to 0.
         if (first) begin
            sof_bus.fmt <= fmt;
            sof_bus.err <= err;
         end
         if (beat.eot) begin
            eof_bus.frm_bytes <= acc + 28'(nbytes);
            eof_bus.last      <= last_cmd;
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/fhp_phd_sender.sv
/*
   Offers buffered header beats on a valid/ready port.
   One beat is held at a time, so a pop never overlaps an acceptance.
*/
`timescale 1ns/10ps
`default_nettype none

module fhp_phd_sender (
   input  logic               clk,
   input  logic               rst_n,
   input  fhp_pkg::phd_beat_t phd_rdata,
   input  logic               phd_empty,
   output logic               phd_rd,
   output fhp_pkg::phd_beat_t phd_bus,
   output logic               phd_valid,
   input  logic               phd_ready,
   output logic               phd_done
);
   import fhp_pkg::*;

   phd_beat_t hold_beat;
   logic      held;

   assign phd_rd    = !phd_empty && !held;
   assign phd_valid = held;
   assign phd_bus   = hold_beat;
   assign phd_done  = held && phd_ready && hold_beat.last;

   always_ff @(posedge clk) begin
      if (phd_rd) begin
         hold_beat <= phd_rdata;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         held <= 1'b0;
      end else if (phd_rd) begin
         held <= 1'b1;
      end else if (phd_ready) begin
         held <= 1'b0;   // offered beat taken.
      end
   end

endmodule

`default_nettype wire

// File: hdl/fhp_phd_buffer.sv
/*
   Header beat FIFO between the parser and the header sender.
   Read data is shown ahead from the head entry.
   There is no overflow guard, the parser stops writing on phd_room
   early enough to keep its in-flight beats inside the depth.
*/
`timescale 1ns/10ps
`default_nettype none

module fhp_phd_buffer (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               phd_wr,
   input  fhp_pkg::phd_beat_t phd_wdata,
   input  logic               phd_rd,
   output fhp_pkg::phd_beat_t phd_rdata,
   output logic               phd_empty,
   output logic               phd_room
);
   import fhp_pkg::*;

   phd_beat_t             mem [PHD_FIFO_DEPTH];
   logic [PHD_PTR_W-1:0]  wr_ptr;
   logic [PHD_PTR_W-1:0]  rd_ptr;
   logic [PHD_USED_W-1:0] used;

   assign phd_rdata = mem[rd_ptr];
   assign phd_empty = (used == '0);
   assign phd_room  = (used < PHD_USED_W'(PHD_ROOM_LIMIT));

   always_ff @(posedge clk) begin
      if (phd_wr) begin
         mem[wr_ptr] <= phd_wdata;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used   <= '0;
      end else begin
         if (phd_wr) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at the power of two depth.
         end
         if (phd_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({phd_wr, phd_rd})
            2'b10:   used <= used + 1'b1;
            2'b01:   used <= used - 1'b1;
            default: used <= used;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/fhp_tlv_parser.sv
/*
   Reads the user TLV stream and routes each beat by the type of its TLV.
   A beat read at one edge is registered and routed at the next one.
   PHD TLVs must carry PHD_WORDS header beats plus one check word,
   otherwise the read hold after the PHD eot is never released.
*/
`timescale 1ns/10ps
`default_nettype none

module fhp_tlv_parser (
   input  logic                clk,
   input  logic                rst_n,
   input  fhp_pkg::tlv_beat_t  usr_tlv,
   input  logic                usr_empty,
   output logic                usr_rd,
   input  logic                dp_ready,
   input  logic                phd_room,
   input  logic                phd_done,
   output logic                phd_wr,
   output fhp_pkg::phd_beat_t  phd_wdata,
   output logic                dat_valid,
   output fhp_pkg::data_beat_t dat_beat
);
   import fhp_pkg::*;

   typedef enum logic [1:0] {st_inactive, st_header, st_data, st_discard} tlv_state_e;

   tlv_state_e           state;
   tlv_state_e           sot_state;
   tlv_beat_t            r_tlv;
   logic                 r_rd;
   logic [PHD_CNT_W-1:0] hdr_cnt;
   logic                 phd_seen;
   logic                 phd_pend;
   logic                 phd_hold;
   logic                 room_ok;
   logic                 dp_ok;

   always_comb begin
      case (usr_tlv.typen)
         tlv_phd:  sot_state = st_header;
         tlv_data: sot_state = st_data;
         default:  sot_state = st_discard;
      endcase
   end

   assign room_ok = (state != st_header) || phd_room;
   assign dp_ok   = (state != st_data) || dp_ready;
   assign usr_rd  = !usr_empty && room_ok && dp_ok && !phd_hold;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= st_inactive;
         r_rd     <= 1'b0;
         phd_pend <= 1'b0;
         phd_hold <= 1'b0;
      end else begin
         r_rd <= usr_rd;
         if (usr_rd && usr_tlv.sot) begin
            state <= sot_state;
         end else if (r_rd && r_tlv.eot) begin
            state <= st_inactive;   // the routed beat closed its TLV.
         end

         if (usr_rd && usr_tlv.sot && (sot_state == st_header)) begin
            phd_pend <= 1'b1;
         end else if (phd_done) begin
            phd_pend <= 1'b0;
         end

         // no reads after a PHD eot until its last header beat has left.
         if (phd_done) begin
            phd_hold <= 1'b0;
         end else if (usr_rd && usr_tlv.eot && !usr_tlv.sot &&
                      (state == st_header) && phd_pend) begin
            phd_hold <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phd_wr    <= 1'b0;
         dat_valid <= 1'b0;
         hdr_cnt   <= '0;
         phd_seen  <= 1'b0;
      end else begin
         phd_wr    <= 1'b0;
         dat_valid <= 1'b0;
         if (r_rd) begin
            case (state)
               st_header: begin
                  if (r_tlv.sot) begin
                     hdr_cnt  <= '0;
                     phd_seen <= 1'b1;
                  end else if (hdr_cnt < PHD_CNT_W'(PHD_WORDS)) begin
                     phd_wr  <= 1'b1;
                     hdr_cnt <= hdr_cnt + 1'b1;
                  end
               end
               st_data: begin
                  dat_valid <= 1'b1;
                  if (r_tlv.sot) begin
                     phd_seen <= 1'b0;   // travels once with the start word.
                  end
               end
               default: begin
               end
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (usr_rd) begin
         r_tlv <= usr_tlv;
      end
      if (r_rd) begin
         phd_wdata.data    <= r_tlv.tdata;
         phd_wdata.last    <= (hdr_cnt == PHD_CNT_W'(PHD_WORDS - 1));
         dat_beat.tlv      <= r_tlv;
         dat_beat.phd_seen <= phd_seen;
      end
   end

endmodule

`default_nettype wire

// File: hdl/fhp_pkg.sv
/*
   Shared types and constants of the front end header parser.
   A TLV start word carries its type in the low byte. Only PHD and
   DATA types are routed, every other type code is read and dropped.
   The header FIFO depth must stay a power of two.
*/
`default_nettype none

package fhp_pkg;

   typedef enum logic [7:0] {
      tlv_rqe  = 8'h01,
      tlv_cmd  = 8'h02,
      tlv_frmd = 8'h03,
      tlv_pfd  = 8'h04,
      tlv_phd  = 8'h05,
      tlv_data = 8'h06,
      tlv_cqe  = 8'h09
   } tlv_type_e;

   localparam int PHD_WORDS      = 6;
   localparam int PHD_FIFO_DEPTH = 8;
   localparam int PHD_ROOM_LIMIT = 4;
   localparam int PHD_CNT_W      = $clog2(PHD_WORDS + 1);
   localparam int PHD_PTR_W      = $clog2(PHD_FIFO_DEPTH);
   localparam int PHD_USED_W     = $clog2(PHD_FIFO_DEPTH + 1);
   localparam int BYTES_PER_BEAT = 8;

   localparam logic [31:0] XP9_MAGIC  = 32'h5a4d_5839;
   localparam logic [31:0] XP10_MAGIC = 32'h5a4d_5830;
   localparam logic [7:0]  GZIP_ID1   = 8'h1f;
   localparam logic [7:0]  GZIP_ID2   = 8'h8b;
   localparam logic [3:0]  ZLIB_CM    = 4'h8;

   typedef struct packed {
      logic [63:0] tdata;
      logic [7:0]  tstrb;
      logic        sot;
      logic        eot;
      logic [7:0]  typen;   // only meaningful when sot is set.
   } tlv_beat_t;

   typedef struct packed {
      logic [55:0] rsvd;
      logic [7:0]  tlv_type;
   } tlv_word0_gen_t;

   typedef struct packed {
      logic [31:0] rsvd;
      logic        last_of_command;
      logic [7:0]  seq_num;
      logic [3:0]  eng_id;
      logic [10:0] frame_num;
      logic [7:0]  tlv_type;
   } tlv_word0_data_t;

   typedef union packed {
      tlv_word0_gen_t  gen;
      tlv_word0_data_t data;
   } tlv_word0_u;

   typedef struct packed {
      logic [63:0] data;
      logic        last;
   } phd_beat_t;

   typedef struct packed {
      tlv_beat_t tlv;
      logic      phd_seen;
   } data_beat_t;

   typedef enum logic [2:0] {none, xp9, xp10, gzip, zlib} sof_fmt_e;

   typedef enum logic [1:0] {no_error, bad_format} fhp_err_e;

   typedef struct packed {
      sof_fmt_e    fmt;
      fhp_err_e    err;
      logic [10:0] frame_num;
      logic [3:0]  eng_id;
      logic [7:0]  seq_num;
      logic        phd_present;
   } sof_bus_t;

   typedef struct packed {
      logic [63:0] data;
      logic        sof;
      logic        eof;
      logic [2:0]  bytes_valid;   // zero means all eight bytes.
   } dp_bus_t;

   typedef struct packed {
      logic [27:0] frm_bytes;
      logic        last;
   } eof_bus_t;

endpackage

`default_nettype wire
